// File: axis2axi.f
hw/axis2axi_pkg.sv
hw/axis2axi_mem_if.sv
hw/axis2axi_buffer_ram.sv
hw/axis2axi_fifo.sv
hw/axis2axi_in.sv
hw/axis2axi_top.sv
verification/axis2axi_axi_slave.sv
verification/axis2axi_tb.sv

// File: Makefile
SIM := obj_dir/Vaxis2axi_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f axis2axi.f --top-module axis2axi_tb -Mdir obj_dir

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: verification/axis2axi_tb.sv
`timescale 1ns/1ps

module axis2axi_tb
   import axis2axi_pkg::*;
();

   localparam int BURST_W    = 3;
   localparam int MAX_BEATS  = 2 ** BURST_W;
   localparam int FIFO_DEPTH = 2 ** (BURST_W + 1);
   localparam int TIMEOUT    = 5000;

   logic        clk_i = 1'b0;
   logic        rst_i;
   logic [31:0] cfg_addr_i;
   logic        cfg_valid_i;
   logic        cfg_ready_o;
   axi_data_t   axis_data_i;
   logic        axis_valid_i;
   logic        axis_ready_o;
   logic [31:0] axi_awaddr_o;
   axi_len_t    axi_awlen_o;
   axi_size_t   axi_awsize_o;
   axi_burst_t  axi_awburst_o;
   logic        axi_awvalid_o;
   logic        axi_awready_i;
   axi_data_t   axi_wdata_o;
   logic [3:0]  axi_wstrb_o;
   logic        axi_wlast_o;
   logic        axi_wvalid_o;
   logic        axi_wready_i;
   logic        axi_bvalid_i;
   logic        axi_bready_o;

   integer      seed;
   int          errors = 0;
   int          accepted_total = 0;
   logic        long_stall = 1'b0;
   logic        ready_dropped;
   logic [31:0] sent_q [$];

   always #2 clk_i = ~clk_i;

   axis2axi_top #(.AXI_ADDR_W(32), .BURST_W(BURST_W)) u_axis2axi_top (.*);

   axis2axi_axi_slave u_slave (
      .clk_i (clk_i), .rst_i (rst_i), .long_stall_i (long_stall),
      .awaddr_i (axi_awaddr_o), .awlen_i (axi_awlen_o), .awsize_i (axi_awsize_o),
      .awburst_i (axi_awburst_o), .awvalid_i (axi_awvalid_o), .awready_o (axi_awready_i),
      .wdata_i (axi_wdata_o), .wstrb_i (axi_wstrb_o), .wlast_i (axi_wlast_o),
      .wvalid_i (axi_wvalid_o), .wready_o (axi_wready_i),
      .bvalid_o (axi_bvalid_i), .bready_i (axi_bready_o)
   );

   task automatic timeout_fail(input string what);
      $display("Timeout while waiting for %s", what);
      $display("SOME TESTS FAILED");
      $finish;
   endtask

   // Stable point between the driving and sampling edges
   always begin
      @(negedge clk_i);
      #1;
      if (!rst_i) begin
         if (accepted_total != u_slave.beat_total || axi_awvalid_o || axi_wvalid_o ||
             u_slave.b_wait != 2'd0) begin
            assert (!cfg_ready_o) else begin
               errors++;
               $display("MISMATCH at %0t: cfg_ready_o high while busy", $time);
            end
         end
         if (!axis_ready_o) begin
            ready_dropped = 1'b1;
            assert (accepted_total - u_slave.beat_total >= FIFO_DEPTH) else begin
               errors++;
               $display("MISMATCH at %0t: axis_ready_o low with %0d words pending", $time,
                        accepted_total - u_slave.beat_total);
            end
         end
      end
   end

   // Called on a falling edge, ready holds until the next rising edge
   task automatic send_word(input logic [31:0] data);
      int   waited;
      logic taken;
      waited = 0;
      taken = 1'b0;
      axis_data_i = data;
      axis_valid_i = 1'b1;
      while (!taken) begin
         taken = axis_ready_o;
         @(negedge clk_i);
         waited++;
         if (!taken && waited > TIMEOUT) begin
            timeout_fail("stream word acceptance");
         end
      end
      accepted_total++;
      sent_q.push_back(data);
   endtask

   task automatic wait_cfg_ready();
      int waited;
      waited = 0;
      while (!cfg_ready_o) begin
         @(negedge clk_i);
         waited++;
         if (waited > TIMEOUT) begin
            timeout_fail("cfg_ready_o");
         end
      end
   endtask

   task automatic wait_idle();
      int waited;
      waited = 0;
      while (u_slave.beat_total != accepted_total || u_slave.b_wait != 2'd0 || !cfg_ready_o) begin
         @(negedge clk_i);
         waited++;
         if (waited > TIMEOUT) begin
            timeout_fail("all buffered words to be written");
         end
      end
   endtask

   task automatic check_bursts(input logic [31:0] base, input int first, input int n,
                               input logic gaps);
      logic [31:0] exp_addr;
      logic [31:0] a;
      int          nb;
      int          off;
      int          beats;
      int          short_cnt;
      exp_addr = base;
      beats = 0;
      short_cnt = 0;
      for (int k = first; k < u_slave.burst_cnt; k++) begin
         a = u_slave.burst_addr[k];
         nb = int'(u_slave.burst_len[k]) + 1;
         off = int'(a % AXI_BOUNDARY);
         assert (a == exp_addr) else begin
            errors++;
            $display("MISMATCH at %0t: burst address %h expected %h", $time, a, exp_addr);
         end
         assert (nb <= MAX_BEATS) else begin
            errors++;
            $display("MISMATCH at %0t: burst of %0d beats", $time, nb);
         end
         assert (off + nb * AXI_BYTES_PER_BEAT <= AXI_BOUNDARY) else begin
            errors++;
            $display("MISMATCH at %0t: burst at %h crosses 4 KB", $time, a);
         end
         if (nb < MAX_BEATS && off + nb * AXI_BYTES_PER_BEAT != AXI_BOUNDARY) begin
            short_cnt++;
         end
         exp_addr = a + 32'(nb * AXI_BYTES_PER_BEAT);
         beats += nb;
      end
      assert (beats == n) else begin
         errors++;
         $display("MISMATCH at %0t: %0d beats for %0d words", $time, beats, n);
      end
      // Continuous stream leaves at most the final burst short
      assert (gaps || short_cnt <= 1) else begin
         errors++;
         $display("MISMATCH at %0t: %0d short bursts without gaps", $time, short_cnt);
      end
   endtask

   task automatic check_memory(input logic [31:0] base);
      logic [31:0] a;
      for (int i = 0; i < sent_q.size(); i++) begin
         a = base + 32'(i * AXI_BYTES_PER_BEAT);
         assert (u_slave.mem_data.exists(a) && u_slave.mem_data[a] == sent_q[i]) else begin
            errors++;
            $display("MISMATCH at %0t: word %0d at %h expected %h", $time, i, a, sent_q[i]);
         end
      end
   endtask

   task automatic run_session(input logic [31:0] base, input int n, input logic gaps,
                              input logic stall);
      int first;
      int r;
      wait_cfg_ready();
      cfg_addr_i = base;
      cfg_valid_i = 1'b1;
      @(negedge clk_i);
      cfg_valid_i = 1'b0;
      first = u_slave.burst_cnt;
      sent_q.delete();
      long_stall = stall;
      ready_dropped = 1'b0;
      for (int i = 0; i < n; i++) begin
         send_word($random(seed));
         r = $random(seed);
         if (gaps && (r & 7) == 0) begin
            axis_valid_i = 1'b0;
            repeat (1 + ((r >> 3) & 3)) @(negedge clk_i);
         end
      end
      axis_valid_i = 1'b0;
      wait_idle();
      check_bursts(base, first, n, gaps);
      check_memory(base);
      if (stall) begin
         assert (ready_dropped) else begin
            errors++;
            $display("axis_ready_o never dropped under long wready stalls");
         end
      end
      long_stall = 1'b0;
   endtask

   initial begin
      logic [31:0] base;
      int          n;
      seed = 32'he1aee73b;
      rst_i = 1'b1;
      cfg_addr_i = '0;
      cfg_valid_i = 1'b0;
      axis_data_i = '0;
      axis_valid_i = 1'b0;
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      @(negedge clk_i);
      assert (!axi_awvalid_o && !axi_wvalid_o && cfg_ready_o && axis_ready_o) else begin
         errors++;
         $display("MISMATCH at %0t: outputs after reset not idle", $time);
      end
      for (int s = 0; s < 12; s++) begin
         base = $random(seed) & 32'hffff_fffc;
         // Some sessions start in the last 256 bytes of a page
         if (s % 3 == 0) begin
            base = {base[31:12], 4'hf, base[7:2], 2'b00};
         end
         n = 1 + int'($unsigned($random(seed)) % 40);
         run_session(base, n, s % 2 == 1, 1'b0);
      end
      base = $random(seed) & 32'hffff_fffc;
      run_session(base, 48, 1'b0, 1'b1);
      $display("Errors: %0d testbench, %0d slave", errors, u_slave.err_cnt);
      if (errors + u_slave.err_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: verification/axis2axi_axi_slave.sv
`timescale 1ns/1ps

module axis2axi_axi_slave (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        long_stall_i,
   input  logic [31:0] awaddr_i,
   input  logic [7:0]  awlen_i,
   input  logic [2:0]  awsize_i,
   input  logic [1:0]  awburst_i,
   input  logic        awvalid_i,
   output logic        awready_o,
   input  logic [31:0] wdata_i,
   input  logic [3:0]  wstrb_i,
   input  logic        wlast_i,
   input  logic        wvalid_i,
   output logic        wready_o,
   output logic        bvalid_o,
   input  logic        bready_i
);

   integer seed = 32'he1aee73b;
   int     r_pos;
   int     r_neg;

   // Written words by byte address
   logic [31:0] mem_data [logic [31:0]];

   // Burst records in arrival order
   logic [31:0] burst_addr [0:1023];
   logic [7:0]  burst_len [0:1023];
   int          burst_cnt = 0;
   int          beat_total = 0;
   int          err_cnt = 0;

   logic [31:0] cur_addr;
   logic [7:0]  cur_len;
   logic [7:0]  beat_idx;
   logic [1:0]  b_wait;

   always @(posedge clk_i) begin
      if (rst_i) begin
         b_wait = 2'd0;
         beat_idx = 8'd0;
         cur_addr = 32'd0;
         cur_len = 8'd0;
      end else begin
         // A response is taken in the cycle it is offered
         if (bvalid_o) begin
            assert (bready_i) else begin
               err_cnt++;
               $display("MISMATCH at %0t: bready low while bvalid high", $time);
            end
         end
         if (awvalid_i && awready_o) begin
            cur_addr = awaddr_i;
            cur_len = awlen_i;
            beat_idx = 8'd0;
            burst_addr[burst_cnt] = awaddr_i;
            burst_len[burst_cnt] = awlen_i;
            burst_cnt++;
            assert (awsize_i == 3'd2 && awburst_i == 2'b01) else begin
               err_cnt++;
               $display("MISMATCH at %0t: awsize %0d awburst %0d", $time, awsize_i, awburst_i);
            end
         end
         if (wvalid_i && wready_o) begin
            assert (wstrb_i == 4'hf) else begin
               err_cnt++;
               $display("MISMATCH at %0t: wstrb %h", $time, wstrb_i);
            end
            assert (beat_idx <= cur_len) else begin
               err_cnt++;
               $display("Beat %0d delivered beyond awlen %0d", beat_idx, cur_len);
            end
            assert (wlast_i == (beat_idx == cur_len)) else begin
               err_cnt++;
               $display("MISMATCH at %0t: wlast %b on beat %0d of awlen %0d",
                        $time, wlast_i, beat_idx, cur_len);
            end
            mem_data[cur_addr + {22'd0, beat_idx, 2'b00}] = wdata_i;
            beat_idx++;
            beat_total++;
            if (wlast_i) begin
               // Response one to three cycles later
               r_pos = $random(seed);
               b_wait = 2'(1 + ((r_pos & 3) % 3));
            end
         end else if (b_wait != 2'd0) begin
            b_wait = b_wait - 2'd1;
         end
      end
   end

   // Random ready stalls, driven away from the sampling edge
   initial begin
      awready_o = 1'b0;
      wready_o = 1'b0;
      bvalid_o = 1'b0;
      forever begin
         @(negedge clk_i);
         if (rst_i) begin
            awready_o <= 1'b0;
            wready_o <= 1'b0;
            bvalid_o <= 1'b0;
         end else begin
            r_neg = $random(seed);
            awready_o <= r_neg[0] | r_neg[1];
            if (long_stall_i) begin
               wready_o <= (r_neg[4:2] == 3'd0);
            end else begin
               wready_o <= r_neg[3] | r_neg[4];
            end
            bvalid_o <= (b_wait == 2'd1);
         end
      end
   end

endmodule

// File: hw/axis2axi_top.sv
`timescale 1ns/1ps

module axis2axi_top
   import axis2axi_pkg::*;
#(
   parameter int AXI_ADDR_W = 32,
   parameter int BURST_W    = 3
) (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Configuration channel
   input  logic [AXI_ADDR_W-1:0]         cfg_addr_i,
   input  logic                          cfg_valid_i,
   output logic                          cfg_ready_o,

   // Input stream
   input  axi_data_t                     axis_data_i,
   input  logic                          axis_valid_i,
   output logic                          axis_ready_o,

   // AXI write master
   output logic [AXI_ADDR_W-1:0]         axi_awaddr_o,
   output axi_len_t                      axi_awlen_o,
   output axi_size_t                     axi_awsize_o,
   output axi_burst_t                    axi_awburst_o,
   output logic                          axi_awvalid_o,
   input  logic                          axi_awready_i,
   output axi_data_t                     axi_wdata_o,
   output logic [AXI_BYTES_PER_BEAT-1:0] axi_wstrb_o,
   output logic                          axi_wlast_o,
   output logic                          axi_wvalid_o,
   input  logic                          axi_wready_i,
   input  logic                          axi_bvalid_i,
   output logic                          axi_bready_o
);

   // Buffer holds two full bursts
   localparam int FIFO_ADDR_W = BURST_W + 1;

   logic                 fifo_w_en;
   logic                 fifo_full;
   logic                 fifo_empty;
   logic                 fifo_r_en;
   axi_data_t            fifo_data;
   logic [FIFO_ADDR_W:0] fifo_level;

   axis2axi_mem_if #(.ADDR_W(FIFO_ADDR_W)) u_mem_if ();

   // Stream handshake
   assign axis_ready_o = !fifo_full;
   assign fifo_w_en    = axis_valid_i && axis_ready_o;

   axis2axi_in #(
      .AXI_ADDR_W (AXI_ADDR_W),
      .BURST_W    (BURST_W)
   ) u_axis2axi_in (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .cfg_addr_i    (cfg_addr_i),
      .cfg_valid_i   (cfg_valid_i),
      .cfg_ready_o   (cfg_ready_o),
      .axis_valid_i  (axis_valid_i),
      .fifo_level_i  (fifo_level),
      .fifo_empty_i  (fifo_empty),
      .fifo_data_i   (fifo_data),
      .fifo_r_en_o   (fifo_r_en),
      .axi_awaddr_o  (axi_awaddr_o),
      .axi_awlen_o   (axi_awlen_o),
      .axi_awsize_o  (axi_awsize_o),
      .axi_awburst_o (axi_awburst_o),
      .axi_awvalid_o (axi_awvalid_o),
      .axi_awready_i (axi_awready_i),
      .axi_wdata_o   (axi_wdata_o),
      .axi_wstrb_o   (axi_wstrb_o),
      .axi_wlast_o   (axi_wlast_o),
      .axi_wvalid_o  (axi_wvalid_o),
      .axi_wready_i  (axi_wready_i),
      .axi_bvalid_i  (axi_bvalid_i),
      .axi_bready_o  (axi_bready_o)
   );

   axis2axi_fifo #(
      .ADDR_W (FIFO_ADDR_W)
   ) u_axis2axi_fifo (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .w_en_i    (fifo_w_en),
      .w_data_i  (axis_data_i),
      .w_full_o  (fifo_full),
      .r_en_i    (fifo_r_en),
      .r_data_o  (fifo_data),
      .r_empty_o (fifo_empty),
      .level_o   (fifo_level),
      .mem       (u_mem_if.fifo)
   );

   axis2axi_buffer_ram #(
      .ADDR_W (FIFO_ADDR_W)
   ) u_axis2axi_buffer_ram (
      .clk_i (clk_i),
      .mem   (u_mem_if.ram)
   );

endmodule

// File: hw/axis2axi_in.sv
`timescale 1ns/1ps

module axis2axi_in
   import axis2axi_pkg::*;
#(
   parameter int AXI_ADDR_W = 32,
   parameter int BURST_W    = 3
) (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Configuration channel
   input  logic [AXI_ADDR_W-1:0]         cfg_addr_i,
   input  logic                          cfg_valid_i,
   output logic                          cfg_ready_o,

   // Stream status and FIFO read side
   input  logic                          axis_valid_i,
   input  logic [BURST_W+1:0]            fifo_level_i,
   input  logic                          fifo_empty_i,
   input  axi_data_t                     fifo_data_i,
   output logic                          fifo_r_en_o,

   // AXI write address channel
   output logic [AXI_ADDR_W-1:0]         axi_awaddr_o,
   output axi_len_t                      axi_awlen_o,
   output axi_size_t                     axi_awsize_o,
   output axi_burst_t                    axi_awburst_o,
   output logic                          axi_awvalid_o,
   input  logic                          axi_awready_i,

   // AXI write data channel
   output axi_data_t                     axi_wdata_o,
   output logic [AXI_BYTES_PER_BEAT-1:0] axi_wstrb_o,
   output logic                          axi_wlast_o,
   output logic                          axi_wvalid_o,
   input  logic                          axi_wready_i,

   // AXI write response channel
   input  logic                          axi_bvalid_i,
   output logic                          axi_bready_o
);

   localparam int BURST_SIZE = 2 ** BURST_W;
   localparam int BEAT_W     = $clog2(AXI_BYTES_PER_BEAT);
   localparam int PAGE_W     = $clog2(AXI_BOUNDARY);

   // Beats in one 4 KB page
   localparam logic [PAGE_W:0] PAGE_BEATS = (PAGE_W + 1)'(AXI_BOUNDARY / AXI_BYTES_PER_BEAT);

   engine_state_t state_q;
   engine_state_t state_d;

   logic [AXI_ADDR_W-1:0] addr_q;
   axi_len_t              awlen_q;
   axi_len_t              beat_cnt_q;

   logic normal_burst;
   logic last_burst;
   logic start_transfer;
   logic beat_done;
   logic read_next;

   logic [BURST_W:0]      avail_words;
   logic [BURST_W:0]      burst_size;
   logic [PAGE_W:0]       page_offset;
   logic [PAGE_W:0]       page_beats_left;
   logic [AXI_ADDR_W-1:0] burst_bytes;

   // Burst start conditions
   assign normal_burst   = (fifo_level_i >= BURST_SIZE);
   assign last_burst     = (fifo_level_i != '0) && (fifo_level_i < BURST_SIZE) && !axis_valid_i;
   assign start_transfer = (state_q == WAIT_DATA) && (normal_burst || last_burst);

   // Burst sizing, limited by the words at hand and the distance to the page end
   always_comb begin
      avail_words = normal_burst ? BURST_SIZE[BURST_W:0] : fifo_level_i[BURST_W:0];

      // Word offset inside the current page
      page_offset = '0;
      page_offset[PAGE_W-BEAT_W-1:0] = addr_q[PAGE_W-1:BEAT_W];
      page_beats_left = PAGE_BEATS - page_offset;

      burst_size = avail_words;
      if ((PAGE_W + 1)'(avail_words) > page_beats_left) begin
         burst_size = page_beats_left[BURST_W:0];
      end
   end

   // Bytes covered by the burst in flight
   assign burst_bytes = (AXI_ADDR_W'(awlen_q) + AXI_ADDR_W'(1)) << BEAT_W;

   // Data handshake
   assign beat_done = axi_wvalid_o && axi_wready_i;

   // The start read primes r_data, each accepted beat but the last fetches the next word
   assign read_next   = beat_done && !axi_wlast_o;
   assign fifo_r_en_o = start_transfer || read_next;

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         WAIT_DATA: begin
            if (start_transfer) begin
               state_d = START_TRANSFER;
            end
         end
         START_TRANSFER: begin
            if (axi_awready_i) begin
               state_d = TRANSFER;
            end
         end
         TRANSFER: begin
            if (beat_done && axi_wlast_o) begin
               state_d = WAIT_BRESP;
            end
         end
         WAIT_BRESP: begin
            // Response code is not inspected
            if (axi_bvalid_i) begin
               state_d = WAIT_DATA;
            end
         end
         default: state_d = WAIT_DATA;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q    <= WAIT_DATA;
         addr_q     <= '0;
         awlen_q    <= '0;
         beat_cnt_q <= '0;
      end else begin
         state_q <= state_d;

         // Length is fixed for the whole burst
         if (start_transfer) begin
            awlen_q <= axi_len_t'(burst_size) - axi_len_t'(1);
         end

         if (state_q == WAIT_DATA) begin
            beat_cnt_q <= '0;
         end else if (beat_done) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end

         // New base from software, otherwise step past the finished burst
         if (cfg_valid_i && cfg_ready_o) begin
            addr_q <= cfg_addr_i;
         end else if (beat_done && axi_wlast_o) begin
            addr_q <= addr_q + burst_bytes;
         end
      end
   end

   // Configuration only while idle with nothing buffered
   assign cfg_ready_o = fifo_empty_i && (state_q == WAIT_DATA);

   // Address channel
   assign axi_awaddr_o  = addr_q;
   assign axi_awlen_o   = awlen_q;
   assign axi_awsize_o  = AXI_SIZE_WORD;
   assign axi_awburst_o = AXI_BURST_INCR;
   assign axi_awvalid_o = (state_q == START_TRANSFER);

   // Data channel, the FIFO always holds the whole burst
   assign axi_wdata_o  = fifo_data_i;
   assign axi_wstrb_o  = '1;
   assign axi_wvalid_o = (state_q == TRANSFER);
   assign axi_wlast_o  = (state_q == TRANSFER) && (beat_cnt_q == awlen_q);

   // Responses are always accepted
   assign axi_bready_o = 1'b1;

endmodule

// File: hw/axis2axi_fifo.sv
`timescale 1ns/1ps

module axis2axi_fifo
   import axis2axi_pkg::*;
#(
   parameter int ADDR_W = 4
) (
   input  logic            clk_i,
   input  logic            rst_i,

   // Write side
   input  logic            w_en_i,
   input  axi_data_t       w_data_i,
   output logic            w_full_o,

   // Read side
   input  logic            r_en_i,
   output axi_data_t       r_data_o,
   output logic            r_empty_o,

   // Number of words held
   output logic [ADDR_W:0] level_o,

   // Storage
   axis2axi_mem_if.fifo    mem
);

   // Full level is 2^ADDR_W, one past the largest pointer value
   localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

   logic [ADDR_W-1:0] w_ptr_q;
   logic [ADDR_W-1:0] r_ptr_q;
   logic [ADDR_W:0]   level_q;

   logic w_ok;
   logic r_ok;

   assign w_full_o  = (level_q == DEPTH);
   assign r_empty_o = (level_q == '0);

   // Requests that would overflow or underflow are dropped
   assign w_ok = w_en_i && !w_full_o;
   assign r_ok = r_en_i && !r_empty_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (w_ok) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (r_ok) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
         // Simultaneous push and pop leave the level unchanged
         case ({w_ok, r_ok})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   // RAM port drive
   assign mem.w_en   = w_ok;
   assign mem.w_addr = w_ptr_q;
   assign mem.w_data = w_data_i;
   assign mem.r_en   = r_ok;
   assign mem.r_addr = r_ptr_q;

   // Read data arrives one cycle after r_en
   assign r_data_o = mem.r_data;
   assign level_o  = level_q;

endmodule

// File: hw/axis2axi_buffer_ram.sv
`timescale 1ns/1ps

module axis2axi_buffer_ram
   import axis2axi_pkg::*;
#(
   parameter int ADDR_W = 4
) (
   input logic           clk_i,
   axis2axi_mem_if.ram   mem
);

   localparam int DEPTH = 2 ** ADDR_W;

   axi_data_t mem_array [DEPTH];

   // Write port
   always_ff @(posedge clk_i) begin
      if (mem.w_en) begin
         mem_array[mem.w_addr] <= mem.w_data;
      end
   end

   // Read port, output holds its value while r_en is low
   always_ff @(posedge clk_i) begin
      if (mem.r_en) begin
         mem.r_data <= mem_array[mem.r_addr];
      end
   end

endmodule

// File: hw/axis2axi_mem_if.sv
`timescale 1ns/1ps

interface axis2axi_mem_if
   import axis2axi_pkg::*;
#(
   parameter int ADDR_W = 4
) ();

   // Write port
   logic              w_en;
   logic [ADDR_W-1:0] w_addr;
   axi_data_t         w_data;

   // Read port, data is registered in the RAM
   logic              r_en;
   logic [ADDR_W-1:0] r_addr;
   axi_data_t         r_data;

   modport fifo (output w_en, w_addr, w_data, r_en, r_addr, input r_data);

   modport ram (input w_en, w_addr, w_data, r_en, r_addr, output r_data);

endinterface

// File: hw/axis2axi_pkg.sv
package axis2axi_pkg;

   // Stream and AXI data word
   typedef logic [31:0] axi_data_t;

   // AXI burst length field, beats minus one
   typedef logic [7:0] axi_len_t;

   // Fixed-function AXI write address fields
   typedef logic [2:0] axi_size_t;
   typedef logic [1:0] axi_burst_t;

   // Write engine states
   typedef enum logic [1:0] {
      WAIT_DATA      = 2'd0,
      START_TRANSFER = 2'd1,
      TRANSFER       = 2'd2,
      WAIT_BRESP     = 2'd3
   } engine_state_t;

   // Every beat moves one full 32-bit word
   localparam int AXI_BYTES_PER_BEAT = 4;

   // Bursts may not cross this address boundary
   localparam int AXI_BOUNDARY = 4096;

   localparam axi_size_t  AXI_SIZE_WORD  = 3'd2;
   localparam axi_burst_t AXI_BURST_INCR = 2'b01;

endpackage
